/* btc_pkg.sv */
// shared types, sizes and mode helpers for the product-code encoder, imported by every block
package btc_pkg;

  // ------------------------------------------------------------------
  // sizes
  // ------------------------------------------------------------------

  // user tag carried with each frame
  localparam int TAG_W = 8;
  // bit address inside one bank, 81 coded bits max
  localparam int BUF_ADDR_W = 7;
  localparam int BUF_DEPTH = 2 ** BUF_ADDR_W;
  // largest row or column info length
  localparam int K_MAX = 8;
  // row/column counters, must hold K_MAX itself
  localparam int CNT_W = $clog2(K_MAX) + 1;

  // ------------------------------------------------------------------
  // enums
  // ------------------------------------------------------------------

  // spc component code, 4 or 8 info bits plus one parity
  typedef enum logic {
    cm_spc4,
    cm_spc8
  } btc_code_mode_t;

  typedef enum logic [1:0] {
    eng_idle,
    eng_rows,
    eng_colpar,
    eng_done
  } btc_eng_state_t;

  // ------------------------------------------------------------------
  // bundles
  // ------------------------------------------------------------------

  // xmode sets row length, ymode number of rows
  typedef struct packed {
    btc_code_mode_t   xmode;
    btc_code_mode_t   ymode;
    logic [TAG_W-1:0] tag;
  } btc_frame_hdr_t;

  // one serial output bit with frame marks
  typedef struct packed {
    logic sop;
    logic eop;
    logic dat;
  } btc_stream_t;

  // single-bit write into the owned bank
  typedef struct packed {
    logic                  write;
    logic [BUF_ADDR_W-1:0] addr;
    logic                  dat;
  } btc_buf_wr_t;

  // info bits per row or column for a mode
  function automatic logic [CNT_W-1:0] mode_k(btc_code_mode_t m);
    return (m == cm_spc8) ? CNT_W'(K_MAX) : CNT_W'(K_MAX / 2);
  endfunction

  // kx*ky info bits in a frame
  function automatic logic [BUF_ADDR_W-1:0] info_len(btc_frame_hdr_t h);
    logic [BUF_ADDR_W-1:0] kx;
    logic [BUF_ADDR_W-1:0] ky;
    kx = BUF_ADDR_W'(mode_k(h.xmode));
    ky = BUF_ADDR_W'(mode_k(h.ymode));
    return kx * ky;
  endfunction

  // (kx+1)*(ky+1) coded bits in a frame
  function automatic logic [BUF_ADDR_W-1:0] coded_len(btc_frame_hdr_t h);
    logic [BUF_ADDR_W-1:0] nx;
    logic [BUF_ADDR_W-1:0] ny;
    nx = BUF_ADDR_W'(mode_k(h.xmode)) + 1'b1;
    ny = BUF_ADDR_W'(mode_k(h.ymode)) + 1'b1;
    return nx * ny;
  endfunction

endpackage

/* btc_enc_source.sv */
// serial info-bit input stage, writes each frame row-major into the input ping-pong buffer
`timescale 1ns/1ps

module btc_enc_source (
  input  logic                    iclk,
  input  logic                    rst_n,
  input  logic                    ival,
  input  logic                    isop,
  input  logic                    idat,
  input  btc_pkg::btc_frame_hdr_t ihdr,
  input  logic                    wfree,
  output logic                    ordy,
  output logic                    obusy,
  output btc_pkg::btc_buf_wr_t    wr,
  output logic                    wdone,
  output btc_pkg::btc_frame_hdr_t whdr
);
  import btc_pkg::*;

  logic                  in_frame;
  logic [BUF_ADDR_W-1:0] bit_cnt;
  logic [BUF_ADDR_W-1:0] cnt_cur;
  btc_frame_hdr_t        hdr_q;
  btc_frame_hdr_t        cur_hdr;
  logic                  acc;
  logic                  start;
  logic                  take;
  logic                  last;
  logic                  wr_en;
  logic [BUF_ADDR_W-1:0] wr_addr;
  logic                  wr_dat;

  // open between frames only with a free bank
  // and not while the finished bank is being handed over
  assign ordy    = in_frame | (wfree & ~wdone);
  assign obusy   = in_frame;
  assign acc     = ival & ordy;
  // bits outside a frame without sop are dropped
  assign start   = acc & isop & ~in_frame;
  assign take    = start | (acc & in_frame);
  // header is live on the sop bit itself
  assign cur_hdr = start ? ihdr : hdr_q;
  assign cnt_cur = start ? '0 : bit_cnt;
  assign last    = take & (cnt_cur == info_len(cur_hdr) - 1'b1);

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      in_frame <= 1'b0;
      bit_cnt  <= '0;
      wr_en    <= 1'b0;
      wdone    <= 1'b0;
    end else begin
      wr_en <= take;
      // hand over one cycle after the last bit, with its write
      wdone <= last;
      if (take) begin
        in_frame <= ~last;
        bit_cnt  <= cnt_cur + 1'b1;
      end
    end
  end

  // write payload and frame header
  always_ff @(posedge iclk) begin
    if (take) begin
      wr_addr <= cnt_cur;
      wr_dat  <= idat;
    end
    if (start) begin
      hdr_q <= ihdr;
    end
  end

  assign wr   = '{write: wr_en, addr: wr_addr, dat: wr_dat};
  assign whdr = hdr_q;

endmodule

/* btc_frame_buffer.sv */
// two-bank ping-pong bit memory with per-bank header, instanced as input and output buffer
`timescale 1ns/1ps

module btc_frame_buffer (
  input  logic                              iclk,
  input  logic                              rst_n,
  input  btc_pkg::btc_buf_wr_t              wr,
  input  logic                              wdone,
  input  btc_pkg::btc_frame_hdr_t           whdr,
  input  logic [btc_pkg::BUF_ADDR_W-1:0]    raddr,
  input  logic                              rdone,
  output logic                              wfree,
  output logic                              rfull,
  output logic                              rdat,
  output btc_pkg::btc_frame_hdr_t           rhdr
);
  import btc_pkg::*;

  // ------------------------------------------------------------------
  // storage
  // ------------------------------------------------------------------

  // bank select is the top address bit
  logic           mem [2*BUF_DEPTH];
  btc_frame_hdr_t hdr_mem [2];

  // ------------------------------------------------------------------
  // bank control
  // ------------------------------------------------------------------

  logic [1:0] full;
  logic       wptr;
  logic       rptr;

  // writer owns wptr bank while it is empty
  assign wfree = ~full[wptr];
  // reader owns rptr bank while it is full
  assign rfull = full[rptr];
  assign rhdr  = hdr_mem[rptr];

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      full <= '0;
      wptr <= 1'b0;
      rptr <= 1'b0;
    end else begin
      // write side hands its bank over
      if (wdone) begin
        full[wptr] <= 1'b1;
        wptr       <= ~wptr;
      end
      // read side gives its bank back
      if (rdone) begin
        full[rptr] <= 1'b0;
        rptr       <= ~rptr;
      end
    end
  end

  // ------------------------------------------------------------------
  // data path
  // ------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (wr.write) begin
      mem[{wptr, wr.addr}] <= wr.dat;
    end
    // header travels with the bank
    if (wdone) begin
      hdr_mem[wptr] <= whdr;
    end
  end

  // registered read, one cycle latency
  always_ff @(posedge iclk) begin
    rdat <= mem[{rptr, raddr}];
  end

endmodule

/* btc_enc_engine.sv */
// spc product encoder core, reads one info frame and writes the parity-extended coded frame
`timescale 1ns/1ps

module btc_enc_engine (
  input  logic                              iclk,
  input  logic                              rst_n,
  input  logic                              rfull,
  input  logic                              rdat,
  input  btc_pkg::btc_frame_hdr_t           rhdr,
  input  logic                              wfree,
  output logic [btc_pkg::BUF_ADDR_W-1:0]    raddr,
  output logic                              rdone,
  output btc_pkg::btc_buf_wr_t              wr,
  output logic                              wdone,
  output btc_pkg::btc_frame_hdr_t           whdr
);
  import btc_pkg::*;

  btc_eng_state_t        state;
  btc_frame_hdr_t        hdr_q;
  logic [CNT_W-1:0]      kx;
  logic [CNT_W-1:0]      ky;
  logic [CNT_W-1:0]      row;
  logic [CNT_W-1:0]      col;
  logic [BUF_ADDR_W-1:0] rd_cnt;
  logic [BUF_ADDR_W-1:0] oa;
  logic                  row_end;
  logic                  s_vld;
  logic                  s_colph;
  logic [CNT_W-1:0]      s_col;
  logic                  rowpar;
  logic [K_MAX-1:0]      colpar;
  logic                  bit_out;

  assign kx      = mode_k(hdr_q.xmode);
  assign ky      = mode_k(hdr_q.ymode);
  // slot kx of a row is its parity slot, no read issued
  assign row_end = (col == kx);

  // ------------------------------------------------------------------
  // slot sequencer
  // ------------------------------------------------------------------

  // one slot per coded bit in output order, so the write address
  // row*(kx+1)+col is a plain running count
  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      state  <= eng_idle;
      row    <= '0;
      col    <= '0;
      rd_cnt <= '0;
      s_vld  <= 1'b0;
      oa     <= '0;
    end else begin
      s_vld <= (state == eng_rows) | (state == eng_colpar);
      if (state == eng_idle) begin
        oa <= '0;
      end else if (s_vld) begin
        oa <= oa + 1'b1;
      end
      case (state)
        eng_idle: begin
          row    <= '0;
          col    <= '0;
          rd_cnt <= '0;
          // wait for a full info bank and a free coded bank
          if (rfull & wfree) begin
            state <= eng_rows;
          end
        end
        eng_rows: begin
          if (!row_end) begin
            rd_cnt <= rd_cnt + 1'b1;
          end
          if (row_end) begin
            col <= '0;
            row <= row + 1'b1;
            if (row == ky - 1'b1) begin
              state <= eng_colpar;
            end
          end else begin
            col <= col + 1'b1;
          end
        end
        eng_colpar: begin
          // column parities, corner in the last slot
          if (row_end) begin
            state <= eng_done;
          end else begin
            col <= col + 1'b1;
          end
        end
        default: begin
          // corner is written this cycle, both banks handed on
          state <= eng_idle;
        end
      endcase
    end
  end

  // slot tag follows the read by one cycle
  always_ff @(posedge iclk) begin
    s_colph <= (state == eng_colpar);
    s_col   <= col;
    if ((state == eng_idle) && rfull && wfree) begin
      hdr_q <= rhdr;
    end
  end

  // ------------------------------------------------------------------
  // parity and write stage
  // ------------------------------------------------------------------

  always_comb begin
    bit_out = rdat;
    if (s_colph) begin
      // corner is the parity of all column parities
      bit_out = (s_col == kx) ? ^colpar : colpar[s_col[CNT_W-2:0]];
    end else if (s_col == kx) begin
      bit_out = rowpar;
    end
  end

  always_ff @(posedge iclk) begin
    if (state == eng_idle) begin
      rowpar <= 1'b0;
      colpar <= '0;
    end else if (s_vld && !s_colph) begin
      if (s_col == kx) begin
        // row closed, restart row parity
        rowpar <= 1'b0;
      end else begin
        rowpar                    <= rowpar ^ rdat;
        colpar[s_col[CNT_W-2:0]]  <= colpar[s_col[CNT_W-2:0]] ^ rdat;
      end
    end
  end

  assign raddr = rd_cnt;
  assign wr    = '{write: s_vld, addr: oa, dat: bit_out};
  assign whdr  = hdr_q;
  assign wdone = (state == eng_done);
  assign rdone = (state == eng_done);

endmodule

/* btc_enc_sink.sv */
// serial output stage, streams each coded frame from the output buffer on consumer request
`timescale 1ns/1ps

module btc_enc_sink (
  input  logic                              iclk,
  input  logic                              rst_n,
  input  logic                              rfull,
  input  logic                              rdat,
  input  btc_pkg::btc_frame_hdr_t           rhdr,
  input  logic                              ireq,
  output logic [btc_pkg::BUF_ADDR_W-1:0]    raddr,
  output logic                              rdone,
  output logic                              oval,
  output btc_pkg::btc_stream_t              ostrm,
  output btc_pkg::btc_frame_hdr_t           ohdr
);
  import btc_pkg::*;

  logic [BUF_ADDR_W-1:0] ra;
  logic [BUF_ADDR_W-1:0] len;
  logic                  rd;
  logic                  last;
  logic                  sop_q;
  logic                  eop_q;

  // coded length of the frame in the read bank
  assign len   = coded_len(rhdr);
  // one read per requested cycle while a frame is pending
  assign rd    = ireq & rfull;
  assign last  = (ra == len - 1'b1);
  // bank freed with its last read, rdat is already captured then
  assign rdone = rd & last;
  assign raddr = ra;

  // ------------------------------------------------------------------
  // read counter and frame marks
  // ------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (!rst_n) begin
      ra    <= '0;
      oval  <= 1'b0;
      sop_q <= 1'b0;
      eop_q <= 1'b0;
    end else begin
      // marks line up with the registered read
      oval  <= rd;
      sop_q <= rd & (ra == '0);
      eop_q <= rd & last;
      if (rd) begin
        ra <= last ? '0 : ra + 1'b1;
      end
    end
  end

  // header sampled before the bank pointer moves on
  always_ff @(posedge iclk) begin
    if (rd) begin
      ohdr <= rhdr;
    end
  end

  assign ostrm = '{sop: sop_q, eop: eop_q, dat: rdat};

endmodule

/* btc_enc.sv */
// encoder top level, chains source, input buffer, engine, output buffer and sink
`timescale 1ns/1ps

module btc_enc (
  input  logic                    iclk,
  input  logic                    rst_n,
  input  logic                    ival,
  input  logic                    isop,
  input  logic                    idat,
  input  btc_pkg::btc_frame_hdr_t ihdr,
  input  logic                    ireq,
  output logic                    ordy,
  output logic                    obusy,
  output logic                    oval,
  output btc_pkg::btc_stream_t    ostrm,
  output btc_pkg::btc_frame_hdr_t ohdr
);
  import btc_pkg::*;

  // ------------------------------------------------------------------
  // buffer nets
  // ------------------------------------------------------------------

  // source to input buffer to engine
  btc_buf_wr_t           ib_wr;
  logic                  ib_wdone;
  btc_frame_hdr_t        ib_whdr;
  logic                  ib_wfree;
  logic                  ib_rfull;
  logic                  ib_rdat;
  btc_frame_hdr_t        ib_rhdr;
  logic [BUF_ADDR_W-1:0] ib_raddr;
  logic                  ib_rdone;
  // engine to output buffer to sink
  btc_buf_wr_t           ob_wr;
  logic                  ob_wdone;
  btc_frame_hdr_t        ob_whdr;
  logic                  ob_wfree;
  logic                  ob_rfull;
  logic                  ob_rdat;
  btc_frame_hdr_t        ob_rhdr;
  logic [BUF_ADDR_W-1:0] ob_raddr;
  logic                  ob_rdone;

  // ------------------------------------------------------------------
  // chain
  // ------------------------------------------------------------------

  btc_enc_source source (
    .iclk  (iclk),
    .rst_n (rst_n),
    .ival  (ival),
    .isop  (isop),
    .idat  (idat),
    .ihdr  (ihdr),
    .wfree (ib_wfree),
    .ordy  (ordy),
    .obusy (obusy),
    .wr    (ib_wr),
    .wdone (ib_wdone),
    .whdr  (ib_whdr)
  );

  btc_frame_buffer ibuf (
    .iclk  (iclk),
    .rst_n (rst_n),
    .wr    (ib_wr),
    .wdone (ib_wdone),
    .whdr  (ib_whdr),
    .raddr (ib_raddr),
    .rdone (ib_rdone),
    .wfree (ib_wfree),
    .rfull (ib_rfull),
    .rdat  (ib_rdat),
    .rhdr  (ib_rhdr)
  );

  btc_enc_engine engine (
    .iclk  (iclk),
    .rst_n (rst_n),
    .rfull (ib_rfull),
    .rdat  (ib_rdat),
    .rhdr  (ib_rhdr),
    .wfree (ob_wfree),
    .raddr (ib_raddr),
    .rdone (ib_rdone),
    .wr    (ob_wr),
    .wdone (ob_wdone),
    .whdr  (ob_whdr)
  );

  btc_frame_buffer obuf (
    .iclk  (iclk),
    .rst_n (rst_n),
    .wr    (ob_wr),
    .wdone (ob_wdone),
    .whdr  (ob_whdr),
    .raddr (ob_raddr),
    .rdone (ob_rdone),
    .wfree (ob_wfree),
    .rfull (ob_rfull),
    .rdat  (ob_rdat),
    .rhdr  (ob_rhdr)
  );

  btc_enc_sink sink (
    .iclk  (iclk),
    .rst_n (rst_n),
    .rfull (ob_rfull),
    .rdat  (ob_rdat),
    .rhdr  (ob_rhdr),
    .ireq  (ireq),
    .raddr (ob_raddr),
    .rdone (ob_rdone),
    .oval  (oval),
    .ostrm (ostrm),
    .ohdr  (ohdr)
  );

endmodule

/* btc_enc_assertions.sv */
// protocol checks on the encoder top level, attached to btc_enc by bind
`timescale 1ns/1ps

module btc_enc_assertions (
  input logic                 iclk,
  input logic                 rst_n,
  input logic                 ival,
  input logic                 ordy,
  input logic                 ireq,
  input logic                 oval,
  input btc_pkg::btc_stream_t ostrm,
  input btc_pkg::btc_buf_wr_t src_wr
);

  // failures so far, polled by the testbench
  int unsigned err_cnt = 0;

  // sink answers a request one cycle later, never on its own
  a_oval_req: assert property (@(posedge iclk) disable iff (!rst_n) oval |-> $past(ireq))
    else begin
      err_cnt++;
      $error("oval without ireq in the previous cycle");
    end

  // frame marks only on a valid bit
  a_marks_val: assert property (@(posedge iclk) disable iff (!rst_n)
    (ostrm.sop | ostrm.eop) |-> oval)
    else begin
      err_cnt++;
      $error("sop or eop outside oval");
    end

  // a source write needs an accepted input bit
  a_acc_rdy: assert property (@(posedge iclk) disable iff (!rst_n)
    src_wr.write |-> $past(ival & ordy))
    else begin
      err_cnt++;
      $error("input bit taken without ordy");
    end

endmodule

bind btc_enc btc_enc_assertions assert_i (
  .iclk   (iclk),
  .rst_n  (rst_n),
  .ival   (ival),
  .ordy   (ordy),
  .ireq   (ireq),
  .oval   (oval),
  .ostrm  (ostrm),
  .src_wr (ib_wr)
);

/* tb_btc_enc.sv */
// testbench for the product-code encoder, random frames checked against an spc product model
`timescale 1ns/1ps

module tb_btc_enc;
  import btc_pkg::*;

  localparam int N_FRAMES    = 40;
  // worst case 81 coded bits per frame with slack per bit for request gaps
  localparam int TIMEOUT_CYC = N_FRAMES * 81 * 8 + 2000;
  // ordy low this long means real back-pressure rather than the hand-over gap
  localparam int STALL_MIN   = 20;
  localparam int HOLD_AT     = 200;
  localparam int HOLD_LEN    = 800;

  logic           iclk;
  logic           rst_n;
  logic           ival;
  logic           isop;
  logic           idat;
  btc_frame_hdr_t ihdr;
  logic           ireq;
  logic           ordy;
  logic           obusy;
  logic           oval;
  btc_stream_t    ostrm;
  btc_frame_hdr_t ohdr;

  logic [31:0]    lcg_state;
  // expected coded bits and headers in input order
  btc_stream_t    exp_q [$];
  btc_frame_hdr_t hdr_q [$];
  logic           in_bits [K_MAX*K_MAX];
  int             in_len;
  int             bit_idx;
  logic           frame_open;
  int             sent;
  int             rcvd;
  int             cyc;
  int             hold_cnt;
  int             stall_cnt;
  logic           saw_stall;

  btc_enc dut_i (
    .iclk  (iclk),
    .rst_n (rst_n),
    .ival  (ival),
    .isop  (isop),
    .idat  (idat),
    .ihdr  (ihdr),
    .ireq  (ireq),
    .ordy  (ordy),
    .obusy (obusy),
    .oval  (oval),
    .ostrm (ostrm),
    .ohdr  (ohdr)
  );

  initial begin
    iclk = 1'b0;
    forever #5 iclk = ~iclk;
  end

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------

  // upper half only since low lcg bits repeat too fast
  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  // even parity over everything the slot covers
  function automatic logic coded_bit(int rr, int cc, int kx, int ky);
    logic b;
    b = 1'b0;
    for (int r = 0; r < ky; r++) begin
      for (int c = 0; c < kx; c++) begin
        if ((rr == ky || rr == r) && (cc == kx || cc == c)) begin
          b = b ^ in_bits[r*kx + c];
        end
      end
    end
    return b;
  endfunction

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_strm(btc_stream_t got, btc_stream_t exp);
    if (got !== exp) begin
      $display("error ostrm: got 0x%h expected 0x%h in frame %0d", got, exp, rcvd);
      abort_run();
    end
  endtask

  task automatic check_hdr(btc_frame_hdr_t got, btc_frame_hdr_t exp);
    if (got !== exp) begin
      $display("error ohdr: got 0x%h expected 0x%h in frame %0d", got, exp, rcvd);
      abort_run();
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("error %s: got 0x%h expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  // new random frame on ihdr and in_bits with its coded image queued
  task automatic new_frame();
    logic [15:0] r;
    int          kx;
    int          ky;
    int          n;
    btc_stream_t s;
    r          = lcg_next();
    ihdr.xmode = r[4] ? cm_spc8 : cm_spc4;
    ihdr.ymode = r[6] ? cm_spc8 : cm_spc4;
    ihdr.tag   = r[15:8];
    kx         = (ihdr.xmode == cm_spc8) ? K_MAX : K_MAX / 2;
    ky         = (ihdr.ymode == cm_spc8) ? K_MAX : K_MAX / 2;
    in_len     = kx * ky;
    for (int i = 0; i < in_len; i++) begin
      r          = lcg_next();
      in_bits[i] = r[12];
    end
    hdr_q.push_back(ihdr);
    n = (kx + 1) * (ky + 1);
    // row-major with parity column last and parity row at the bottom
    for (int rr = 0; rr <= ky; rr++) begin
      for (int cc = 0; cc <= kx; cc++) begin
        s.sop = (rr == 0) && (cc == 0);
        s.eop = (rr * (kx + 1) + cc) == (n - 1);
        s.dat = coded_bit(rr, cc, kx, ky);
        exp_q.push_back(s);
      end
    end
  endtask

  // ------------------------------------------------------------------
  // stimulus and checking
  // ------------------------------------------------------------------

  initial begin
    logic [15:0] r;
    lcg_state  = 32'd94;
    rst_n      = 1'b0;
    ival       = 1'b0;
    isop       = 1'b0;
    idat       = 1'b0;
    ihdr       = '0;
    ireq       = 1'b0;
    in_len     = 0;
    bit_idx    = 0;
    frame_open = 1'b0;
    sent       = 0;
    rcvd       = 0;
    cyc        = 0;
    hold_cnt   = 0;
    stall_cnt  = 0;
    saw_stall  = 1'b0;
    repeat (16) @(posedge iclk);
    @(negedge iclk);
    // idle straight out of reset
    check_flag("oval", oval, 1'b0);
    check_flag("obusy", obusy, 1'b0);
    check_flag("ordy", ordy, 1'b1);
    rst_n = 1'b1;

    while (rcvd < N_FRAMES) begin
      @(negedge iclk);
      cyc++;
      if (cyc > TIMEOUT_CYC) begin
        $display("timeout with %0d of %0d frames out", rcvd, N_FRAMES);
        abort_run();
      end
      if (dut_i.assert_i.err_cnt != 0) begin
        $display("protocol assertion fired");
        abort_run();
      end
      // output side is registered so stable at the falling edge
      if (oval) begin
        if (exp_q.size() == 0) begin
          $display("output bit came out with no frame outstanding");
          abort_run();
        end
        check_strm(ostrm, exp_q.pop_front());
        check_hdr(ohdr, hdr_q[0]);
        if (ostrm.eop) begin
          void'(hdr_q.pop_front());
          rcvd++;
        end
      end
      // source busy from the taken sop bit until its last bit is taken
      check_flag("obusy", obusy, bit_idx != 0);
      // long ordy low only under back-pressure
      if (!ordy) begin
        stall_cnt++;
        if (stall_cnt >= STALL_MIN) begin
          saw_stall = 1'b1;
        end
      end else begin
        stall_cnt = 0;
      end
      // request gaps plus a few long holds
      r = lcg_next();
      if (cyc == HOLD_AT) begin
        hold_cnt = HOLD_LEN;
      end else if (hold_cnt == 0 && r[7:0] == 8'd0) begin
        hold_cnt = 400 + 2 * r[15:8];
      end
      if (hold_cnt > 0) begin
        ireq     = 1'b0;
        hold_cnt = hold_cnt - 1;
      end else begin
        ireq = (r[11:10] != 2'b00);
      end
      // ordy is register-driven and holds to the next edge
      r = lcg_next();
      if (!frame_open && sent < N_FRAMES) begin
        new_frame();
        frame_open = 1'b1;
      end
      if (frame_open && r[1:0] != 2'b00) begin
        ival = 1'b1;
        isop = (bit_idx == 0);
        idat = in_bits[bit_idx];
        if (ordy) begin
          bit_idx++;
          if (bit_idx == in_len) begin
            bit_idx    = 0;
            frame_open = 1'b0;
            sent++;
          end
        end
      end else begin
        ival = 1'b0;
        isop = 1'b0;
        idat = 1'b0;
      end
    end

    // nothing may trail the last frame
    ival = 1'b0;
    isop = 1'b0;
    ireq = 1'b1;
    repeat (20) begin
      @(negedge iclk);
      check_flag("oval", oval, 1'b0);
    end

    if (exp_q.size() != 0 || hdr_q.size() != 0) begin
      $display("model still holds bits after the last frame");
      abort_run();
    end else if (!saw_stall) begin
      $display("ordy never dropped under back-pressure");
      abort_run();
    end else if (dut_i.assert_i.err_cnt != 0) begin
      $display("protocol assertion fired");
      abort_run();
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

/* flist.f */
btc_pkg.sv
btc_enc_source.sv
btc_frame_buffer.sv
btc_enc_engine.sv
btc_enc_sink.sv
btc_enc.sv
btc_enc_assertions.sv
tb_btc_enc.sv
